// File: tb.f
src/lf_pkg.sv
src/ladner_fischer_tree.sv
src/lf_adder.sv
src/add_pipeline.sv
src/result_fifo.sv
src/apb_regs.sv
src/lf_adder_apb_top.sv
testbench/lf_adder_assert.sv
testbench/tb_lf_adder.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_lf_adder
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_lf_adder.sv
// Adder accelerator testbench
`timescale 1ns/1ps

module tb_lf_adder import lf_pkg::*;;

	// Corners, random, latency and back-pressure additions
	localparam int N_ADDS = 7 + 200 + 1 + 7;

	logic              clk;
	logic              reset;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [APB_AW-1:0] paddr;
	logic [31:0]       pwdata;
	logic [31:0]       prdata;
	logic              pready;
	logic              pslverr;

	int                errors;
	int                assert_fails;
	logic [LF_WIDTH:0] exp_q[$];
	logic [LF_WIDTH-1:0] op_a;
	logic [LF_WIDTH-1:0] op_b;
	logic              op_cin;
	logic [31:0]       rd_data;
	logic              rd_err;

	lf_adder_apb_top #(.WIDTH(LF_WIDTH), .DEPTH(LF_FIFO_DEPTH)) i_lf_adder_apb_top (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #50 clk = ~clk;

	// One APB transfer, outputs sampled 1 ns after the falling edge
	task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		while (!pready) begin
			@(negedge clk);
			#1;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
		logic [31:0] unused_data;
		logic        unused_err;
		apb_xfer(1'b1, addr, data, unused_data, unused_err);
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
			output logic err);
		apb_xfer(1'b0, addr, 32'h0, data, err);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected) else begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		assert (ok) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	// Start write with stored operands, reference is a + b + cin
	task automatic launch(input logic [LF_WIDTH-1:0] a, input logic [LF_WIDTH-1:0] b,
			input logic cin);
		apb_write(ADDR_CTRL, {30'b0, 1'b1, cin});
		exp_q.push_back((LF_WIDTH+1)'(a) + (LF_WIDTH+1)'(b) + (LF_WIDTH+1)'(cin));
	endtask

	task automatic add_op(input logic [LF_WIDTH-1:0] a, input logic [LF_WIDTH-1:0] b,
			input logic cin);
		apb_write(ADDR_OPA, 32'(a));
		apb_write(ADDR_OPB, 32'(b));
		launch(a, b, cin);
	endtask

	task automatic check_result(input string name);
		logic [31:0]       data;
		logic              err;
		logic [LF_WIDTH:0] expected;
		apb_read(ADDR_RESULT, data, err);
		check_true(!err, {"RESULT read returned an error response in ", name});
		if (exp_q.size() == 0) begin
			check_true(1'b0, {"RESULT read with no expected value in ", name});
		end else begin
			expected = exp_q.pop_front();
			check_value(name, 32'(expected), data);
		end
	endtask

	// Start write on a full pipeline, held for some cycles and then withdrawn
	task automatic start_held(input int cycles);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = ADDR_CTRL;
		pwdata = 32'h2;
		@(negedge clk);
		penable = 1'b1;
		repeat (cycles) begin
			#1;
			check_true(!pready, "Start write on a full pipeline was not held");
			@(negedge clk);
		end
		psel = 1'b0;
		penable = 1'b0;
	endtask

	initial begin
		repeat (N_ADDS * 20 + 200) @(posedge clk);
		$display("Timeout: the tests did not finish in %0d cycles", N_ADDS * 20 + 200);
		$display("Something failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		void'($urandom(34004));
		repeat (2) @(negedge clk);
		reset = 1'b0;

		// Directed corners
		add_op(24'h000000, 24'h000000, 1'b0);
		check_result("corner zeros");
		add_op(24'hFFFFFF, 24'hFFFFFF, 1'b1);
		check_result("corner ones with carry-in");
		add_op(24'hAAAAAA, 24'h555555, 1'b1);
		check_result("corner alternating with carry-in");
		add_op(24'h555555, 24'h555555, 1'b0);
		check_result("corner alternating");
		add_op(24'hFFFFFF, 24'h000000, 1'b1);
		check_result("corner full carry chain");
		add_op(24'h000001, 24'h7FFFFF, 1'b0);
		check_result("corner carry chain");
		add_op(24'h800000, 24'h800000, 1'b0);
		check_result("corner top carry-out");

		for (int n = 0; n < 200; n++) begin
			op_a = LF_WIDTH'($urandom());
			op_b = LF_WIDTH'($urandom());
			op_cin = 1'($urandom());
			add_op(op_a, op_b, op_cin);
			check_result("random");
		end

		// Register readback, start bit never stored
		op_a = LF_WIDTH'($urandom());
		op_b = LF_WIDTH'($urandom());
		apb_write(ADDR_OPA, 32'(op_a));
		apb_write(ADDR_OPB, 32'(op_b));
		apb_write(ADDR_CTRL, 32'h1);
		apb_read(ADDR_OPA, rd_data, rd_err);
		check_value("readback opa", 32'(op_a), rd_data);
		apb_read(ADDR_OPB, rd_data, rd_err);
		check_value("readback opb", 32'(op_b), rd_data);
		apb_read(ADDR_CTRL, rd_data, rd_err);
		check_value("readback ctrl", 32'h1, rd_data);

		// Launch latency with an empty pipeline
		launch(op_a, op_b, 1'b1);
		apb_read(ADDR_STATUS, rd_data, rd_err);
		check_value("launch latency", 32'h1, rd_data & 32'hF);
		check_result("latency");
		// Start was written as one, only the carry-in remains
		apb_read(ADDR_CTRL, rd_data, rd_err);
		check_value("readback start", 32'h1, rd_data);

		// Fill FIFO and both stages
		for (int n = 0; n < 6; n++) begin
			op_a = LF_WIDTH'($urandom());
			op_b = LF_WIDTH'($urandom());
			add_op(op_a, op_b, 1'b0);
		end
		apb_read(ADDR_STATUS, rd_data, rd_err);
		check_value("status full", 32'h604, rd_data);
		start_held(5);
		check_result("backpressure");
		launch(op_a, op_b, 1'b0);
		repeat (6) check_result("backpressure");

		// Error responses
		apb_read(ADDR_RESULT, rd_data, rd_err);
		check_true(rd_err, "RESULT read on an empty FIFO gave no error response");
		check_value("empty result data", 32'h0, rd_data);
		apb_read(8'h14, rd_data, rd_err);
		check_true(rd_err, "Unmapped address gave no error response");
		apb_read(ADDR_STATUS, rd_data, rd_err);
		check_value("status drained", 32'h100, rd_data);

		repeat (4) @(posedge clk);
		assert_fails = i_lf_adder_apb_top.i_lf_adder_assert.fail_count;
		$display("Closing report: %0d check errors, %0d assertion failures",
			errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: testbench/lf_adder_assert.sv
// Adder accelerator assertions
`timescale 1ns/1ps

module lf_adder_assert #(
	parameter int WIDTH = 24
) (
	input logic             clk,
	input logic             reset,
	input logic             psel,
	input logic             penable,
	input logic             pready,
	input logic             pslverr,
	input logic             in_valid,
	input logic             in_ready,
	input logic             push,
	input logic             pop,
	input logic             full,
	input logic             empty,
	input logic             busy,
	input logic [WIDTH-1:0] add_a,
	input logic [WIDTH-1:0] add_b,
	input logic             add_cin,
	input logic [WIDTH-1:0] add_sum,
	input logic             add_cout
);

	int fail_count = 0;

	// Prefix adder against plain addition
	a_adder_sum: assert property (@(posedge clk) disable iff (reset)
		busy |-> ({add_cout, add_sum} == (WIDTH+1)'(add_a) + (WIDTH+1)'(add_b)
			+ (WIDTH+1)'(add_cin)))
		else begin fail_count++; $error("Adder sum differs from a + b + cin"); end

	// Unstalled launch reaches the FIFO two cycles later
	a_launch_latency: assert property (@(posedge clk) disable iff (reset)
		$past(in_valid && in_ready, 2) && !$past(full) && !full |-> push)
		else begin fail_count++; $error("Push did not follow launch after 2 cycles"); end

	a_no_push_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
		else begin fail_count++; $error("FIFO pushed while full"); end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else begin fail_count++; $error("FIFO popped while empty"); end

	a_setup_access: assert property (@(posedge clk) disable iff (reset)
		psel && !penable |=> psel && penable)
		else begin fail_count++; $error("APB setup not followed by access"); end

	a_slverr_complete: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> psel && penable && pready)
		else begin fail_count++; $error("pslverr outside a completing access"); end

endmodule

bind lf_adder_apb_top lf_adder_assert #(.WIDTH(WIDTH)) i_lf_adder_assert (
	.clk(clk), .reset(reset),
	.psel(psel), .penable(penable), .pready(pready), .pslverr(pslverr),
	.in_valid(in_valid), .in_ready(in_ready),
	.push(push), .pop(pop), .full(full), .empty(empty), .busy(busy),
	.add_a(i_add_pipeline.i_lf_adder.a),
	.add_b(i_add_pipeline.i_lf_adder.b),
	.add_cin(i_add_pipeline.i_lf_adder.cin),
	.add_sum(i_add_pipeline.i_lf_adder.sum),
	.add_cout(i_add_pipeline.i_lf_adder.cout)
);

// File: src/lf_adder_apb_top.sv
// APB adder accelerator top
`timescale 1ns/1ps

module lf_adder_apb_top import lf_pkg::*; #(
	parameter int WIDTH = LF_WIDTH,
	parameter int DEPTH = LF_FIFO_DEPTH
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr
);

	localparam int CW = $clog2(DEPTH + 1);

	// Launch handshake
	logic             in_valid;
	logic             in_ready;
	logic [WIDTH-1:0] in_a;
	logic [WIDTH-1:0] in_b;
	logic             in_cin;
	logic             busy;

	// FIFO write and read sides
	logic             push;
	logic [WIDTH-1:0] push_sum;
	logic             push_cout;
	logic             pop;
	logic [WIDTH-1:0] head_sum;
	logic             head_cout;
	logic [CW-1:0]    count;
	logic             empty;
	logic             full;

	apb_regs #(.WIDTH(WIDTH), .DEPTH(DEPTH)) i_apb_regs (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.in_valid(in_valid), .in_a(in_a), .in_b(in_b), .in_cin(in_cin),
		.in_ready(in_ready), .pop(pop),
		.head_sum(head_sum), .head_cout(head_cout),
		.count(count), .empty(empty), .full(full), .busy(busy)
	);

	add_pipeline #(.WIDTH(WIDTH)) i_add_pipeline (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_a(in_a), .in_b(in_b), .in_cin(in_cin),
		.in_ready(in_ready), .busy(busy),
		.push(push), .push_sum(push_sum), .push_cout(push_cout),
		.full(full)
	);

	result_fifo #(.WIDTH(WIDTH), .DEPTH(DEPTH)) i_result_fifo (
		.clk(clk), .reset(reset),
		.push(push), .push_sum(push_sum), .push_cout(push_cout),
		.pop(pop),
		.head_sum(head_sum), .head_cout(head_cout),
		.count(count), .empty(empty), .full(full)
	);

endmodule

// File: src/apb_regs.sv
// APB register block
`timescale 1ns/1ps

module apb_regs import lf_pkg::*; #(
	parameter int WIDTH = LF_WIDTH,
	parameter int DEPTH = LF_FIFO_DEPTH,
	localparam int CW = $clog2(DEPTH + 1)
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output logic              in_valid,
	output logic [WIDTH-1:0]  in_a,
	output logic [WIDTH-1:0]  in_b,
	output logic              in_cin,
	input  logic              in_ready,
	output logic              pop,
	input  logic [WIDTH-1:0]  head_sum,
	input  logic              head_cout,
	input  logic [CW-1:0]     count,
	input  logic              empty,
	input  logic              full,
	input  logic              busy
);

	logic             access;
	logic             complete;
	logic             read_err;
	logic [31:0]      read_data;
	logic [WIDTH-1:0] opa_q;
	logic [WIDTH-1:0] opb_q;
	logic             cin_q;

	assign access = psel && penable;

	// Start write launches straight from the access phase
	assign in_valid = access && pwrite && (paddr == ADDR_CTRL) && pwdata[1];

	// Wait states only while the pipeline refuses a launch
	assign pready = access && !(in_valid && !in_ready);
	assign complete = access && pready;

	assign in_a = opa_q;
	assign in_b = opb_q;
	// Carry-in written together with start takes effect at once
	assign in_cin = in_valid ? pwdata[0] : cin_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			opa_q <= '0;
			opb_q <= '0;
			cin_q <= 1'b0;
		end else if (complete && pwrite) begin
			case (paddr)
				ADDR_OPA:  opa_q <= pwdata[WIDTH-1:0];
				ADDR_OPB:  opb_q <= pwdata[WIDTH-1:0];
				ADDR_CTRL: cin_q <= pwdata[0];
				default: ;
			endcase
		end
	end

	// Read mux and error decode
	always_comb begin
		read_data = '0;
		read_err = 1'b0;
		case (paddr)
			ADDR_OPA:  read_data[WIDTH-1:0] = opa_q;
			ADDR_OPB:  read_data[WIDTH-1:0] = opb_q;
			ADDR_CTRL: read_data[0] = cin_q;
			ADDR_RESULT: begin
				if (!pwrite) begin
					if (empty) begin
						read_err = 1'b1;
					end else begin
						read_data[WIDTH:0] = {head_cout, head_sum};
					end
				end
			end
			ADDR_STATUS: begin
				read_data[CW-1:0] = count;
				read_data[8] = empty;
				read_data[9] = full;
				read_data[10] = busy;
			end
			default: read_err = 1'b1;
		endcase
	end

	assign prdata = (access && !pwrite) ? read_data : '0;
	assign pslverr = complete && read_err;

	// Pop the head when a good RESULT read completes
	assign pop = complete && !pwrite && (paddr == ADDR_RESULT) && !empty;

endmodule

// File: src/result_fifo.sv
// Result FIFO
`timescale 1ns/1ps

module result_fifo import lf_pkg::*; #(
	parameter int WIDTH = LF_WIDTH,
	parameter int DEPTH = LF_FIFO_DEPTH,
	localparam int CW = $clog2(DEPTH + 1),
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic [WIDTH-1:0] push_sum,
	input  logic             push_cout,
	input  logic             pop,
	output logic [WIDTH-1:0] head_sum,
	output logic             head_cout,
	output logic [CW-1:0]    count,
	output logic             empty,
	output logic             full
);

	logic [WIDTH:0]  mem [DEPTH];
	logic [PW-1:0]   wr_ptr;
	logic [PW-1:0]   rd_ptr;
	logic            wr_en;
	logic            rd_en;

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));

	// First-word head
	assign {head_cout, head_sum} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= {push_cout, push_sum};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

endmodule

// File: src/add_pipeline.sv
// Two-stage adder pipeline
`timescale 1ns/1ps

module add_pipeline import lf_pkg::*; #(
	parameter int WIDTH = LF_WIDTH
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  logic [WIDTH-1:0] in_a,
	input  logic [WIDTH-1:0] in_b,
	input  logic             in_cin,
	output logic             in_ready,
	output logic             busy,
	output logic             push,
	output logic [WIDTH-1:0] push_sum,
	output logic             push_cout,
	input  logic             full
);

	logic             s1_valid;
	logic [WIDTH-1:0] s1_a;
	logic [WIDTH-1:0] s1_b;
	logic             s1_cin;
	logic             s2_valid;
	logic             s2_ready;
	logic [WIDTH-1:0] sum;
	logic             cout;

	lf_adder #(.WIDTH(WIDTH)) i_lf_adder (
		.a(s1_a),
		.b(s1_b),
		.cin(s1_cin),
		.sum(sum),
		.cout(cout)
	);

	// Stage 2 drains into the FIFO unless it is full
	assign push = s2_valid && !full;
	assign s2_ready = !s2_valid || push;
	assign in_ready = !s1_valid || s2_ready;
	assign busy = s1_valid || s2_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (in_ready)
				s1_valid <= in_valid;
			if (s2_ready)
				s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			s1_a <= in_a;
			s1_b <= in_b;
			s1_cin <= in_cin;
		end
		if (s1_valid && s2_ready) begin
			push_sum <= sum;
			push_cout <= cout;
		end
	end

endmodule

// File: src/lf_adder.sv
// Ladner-Fischer prefix adder
`timescale 1ns/1ps

module lf_adder import lf_pkg::*; #(
	parameter int WIDTH = LF_WIDTH
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             cin,
	output logic [WIDTH-1:0] sum,
	output logic             cout
);

	logic [WIDTH:0]   p;
	logic [WIDTH:0]   g;
	logic [WIDTH-1:0] c;

	// Carry-in rides as generate of an extra bit zero
	assign p = {a ^ b, 1'b0};
	assign g = {a & b, cin};

	ladner_fischer_tree #(.WIDTH(WIDTH)) i_tree (
		.p(p[WIDTH-1:0]),
		.g(g[WIDTH-1:0]),
		.c(c)
	);

	// c[k] is the carry into operand bit k
	assign sum = p[WIDTH:1] ^ c;
	assign cout = g[WIDTH] | (p[WIDTH] & c[WIDTH-1]);

endmodule

// File: src/ladner_fischer_tree.sv
// Ladner-Fischer carry network
`timescale 1ns/1ps

module ladner_fischer_tree #(
	parameter int WIDTH
) (
	input  logic [WIDTH-1:0] p,
	input  logic [WIDTH-1:0] g,
	output logic [WIDTH-1:0] c
);

	// Doubling stages over the odd positions after pairing
	localparam int STAGES = (WIDTH > 2) ? $clog2(WIDTH) - 1 : 0;

	wire [WIDTH-1:0] gs [STAGES+1];
	wire [WIDTH-1:0] ps [STAGES+1];

	genvar i, s;
	generate
		// Pair each odd bit with the even bit below it
		for (i = 0; i < WIDTH; i++) begin : g_pair
			if (i % 2 == 0) begin : g_pass
				assign gs[0][i] = g[i];
				assign ps[0][i] = p[i];
			end else if (i == 1) begin : g_grey
				assign gs[0][i] = g[i] | (p[i] & g[i-1]);
				assign ps[0][i] = 1'b0;
			end else begin : g_black
				assign gs[0][i] = g[i] | (p[i] & g[i-1]);
				assign ps[0][i] = p[i] & p[i-1];
			end
		end

		// Odd bits in the upper half of each block join its lower half
		for (s = 1; s <= STAGES; s++) begin : g_stage
			for (i = 0; i < WIDTH; i++) begin : g_bit
				localparam int lo_bit = ((i >> s) << s) - 1;
				if (i % 2 == 0 || ((i >> s) & 1) == 0) begin : g_pass
					assign gs[s][i] = gs[s-1][i];
					assign ps[s][i] = ps[s-1][i];
				end else if ((i >> (s + 1)) == 0) begin : g_grey
					// Group now reaches bit 0, propagate no longer needed
					assign gs[s][i] = gs[s-1][i] | (ps[s-1][i] & gs[s-1][lo_bit]);
					assign ps[s][i] = 1'b0;
				end else begin : g_black
					assign gs[s][i] = gs[s-1][i] | (ps[s-1][i] & gs[s-1][lo_bit]);
					assign ps[s][i] = ps[s-1][i] & ps[s-1][lo_bit];
				end
			end
		end

		// Even positions finish with one grey cell, c[k] = G[k:0]
		for (i = 0; i < WIDTH; i++) begin : g_carry
			if (i % 2 == 1 || i == 0) begin : g_direct
				assign c[i] = gs[STAGES][i];
			end else begin : g_grey
				assign c[i] = gs[STAGES][i] | (ps[STAGES][i] & c[i-1]);
			end
		end
	endgenerate

endmodule

// File: src/lf_pkg.sv
// Ladner-Fischer adder definitions
package lf_pkg;

	// Default operand width, single-precision significand
	localparam int LF_WIDTH = 24;

	// Default result FIFO depth in entries
	localparam int LF_FIFO_DEPTH = 4;

	// APB address width
	localparam int APB_AW = 8;

	// Register offsets
	localparam logic [APB_AW-1:0] ADDR_OPA = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_OPB = 8'h04;
	// Bit 0 carry-in, bit 1 start (self-clearing)
	localparam logic [APB_AW-1:0] ADDR_CTRL = 8'h08;
	// Read pops the head, carry-out sits above the sum
	localparam logic [APB_AW-1:0] ADDR_RESULT = 8'h0C;
	// Count in 3..0, empty 8, full 9, busy 10
	localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h10;

endpackage
